//--- rtl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register file sizes
`define RV_XLEN   32
`define RV_REG_AW 5
`define RV_NREGS  32

// Major opcodes, taken from instr[6:2]
`define OPC_ARI_RTYPE 5'b01100
`define OPC_ARI_ITYPE 5'b00100
`define OPC_LUI       5'b01101

// funct3 codes for the arithmetic groups
`define FNC_ADD_SUB 3'b000
`define FNC_SLL     3'b001
`define FNC_SLT     3'b010
`define FNC_SLTU    3'b011
`define FNC_XOR     3'b100
`define FNC_SRL_SRA 3'b101
`define FNC_OR      3'b110
`define FNC_AND     3'b111

// ALU operation codes, decoded once and carried down the pipe
`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_XOR    4'd4
`define ALU_SLL    4'd5
`define ALU_SRL    4'd6
`define ALU_SRA    4'd7
`define ALU_SLT    4'd8
`define ALU_SLTU   4'd9
`define ALU_PASS_B 4'd10 // LUI result comes straight from the immediate

`endif

//--- rtl/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

  // Data words and raw instruction words
  typedef logic [`RV_XLEN-1:0] word_t;

  // Architectural register index, x0 to x31
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Encoded ALU operation, see ALU_* codes
  typedef logic [3:0] alu_op_t;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_addr] <= wr_data; // Decode never issues a write to x0
    end
  end

  // Asynchronous reads, same-cycle writes are not bypassed here
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   y
);

  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic                        lt_signed;
  logic                        lt_unsigned;

  assign shamt       = b[$clog2(`RV_XLEN)-1:0]; // Only the low bits count
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      `ALU_ADD:    y = a + b;
      `ALU_SUB:    y = a - b;
      `ALU_AND:    y = a & b;
      `ALU_OR:     y = a | b;
      `ALU_XOR:    y = a ^ b;
      `ALU_SLL:    y = a << shamt;
      `ALU_SRL:    y = a >> shamt;
      `ALU_SRA:    y = $signed(a) >>> shamt;
      `ALU_SLT:    y = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      `ALU_SLTU:   y = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      `ALU_PASS_B: y = b;
      default:     y = '0; // Unused codes
    endcase
  end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module decode_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  rv_pkg::word_t     instr,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  logic              wb_valid,
  input  rv_pkg::reg_addr_t wb_rd,
  input  rv_pkg::word_t     wb_data,
  output logic              x_valid,
  output rv_pkg::reg_addr_t x_rd,
  output rv_pkg::reg_addr_t x_rs1,
  output rv_pkg::reg_addr_t x_rs2,
  output rv_pkg::word_t     x_op1,
  output rv_pkg::word_t     x_op2,
  output rv_pkg::word_t     x_imm,
  output logic              x_use_imm,
  output rv_pkg::alu_op_t   x_alu_op
);

  logic              d_valid;
  rv_pkg::word_t     d_instr;
  logic [4:0]        opcode;
  logic [2:0]        funct3;
  logic              bit30;
  rv_pkg::reg_addr_t rd;
  logic              legal;
  logic              wr_en;
  logic              use_imm;
  rv_pkg::alu_op_t   alu_op;
  rv_pkg::word_t     imm;
  rv_pkg::word_t     op1;
  rv_pkg::word_t     op2;

  // Shared by R-type and I-type, sub only exists for R-type
  function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic b30,
                                               input logic rtype);
    rv_pkg::alu_op_t op;
    case (f3)
      `FNC_ADD_SUB: op = (rtype && b30) ? `ALU_SUB : `ALU_ADD;
      `FNC_SLL:     op = `ALU_SLL;
      `FNC_SLT:     op = `ALU_SLT;
      `FNC_SLTU:    op = `ALU_SLTU;
      `FNC_XOR:     op = `ALU_XOR;
      `FNC_SRL_SRA: op = b30 ? `ALU_SRA : `ALU_SRL;
      `FNC_OR:      op = `ALU_OR;
      `FNC_AND:     op = `ALU_AND;
      default:      op = `ALU_ADD;
    endcase
    return op;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    d_instr <= instr;
  end

  assign opcode   = d_instr[6:2];
  assign funct3   = d_instr[14:12];
  assign bit30    = d_instr[30];
  assign rd       = d_instr[11:7];
  assign rs1_addr = d_instr[19:15];
  assign rs2_addr = d_instr[24:20]; // Immediate bits for I-type, harmless

  always_comb begin
    legal   = 1'b1;
    use_imm = 1'b1;
    alu_op  = `ALU_ADD;
    imm     = {{20{d_instr[31]}}, d_instr[31:20]}; // I-type form
    case (opcode)
      `OPC_ARI_RTYPE: begin
        use_imm = 1'b0;
        alu_op  = arith_op(funct3, bit30, 1'b1);
      end
      `OPC_ARI_ITYPE: begin
        alu_op = arith_op(funct3, bit30, 1'b0);
      end
      `OPC_LUI: begin
        alu_op = `ALU_PASS_B;
        imm    = {d_instr[31:12], 12'b0}; // U-type form
      end
      default: begin
        legal = 1'b0; // Everything else becomes a bubble
      end
    endcase
  end

  // Writes to x0 are dropped here and nowhere else
  assign wr_en = d_valid && legal && (rd != '0);

  // Two-cycle hazard, value is in write-forward but not yet in the file
  assign op1 = (wb_valid && (wb_rd == rs1_addr)) ? wb_data : rs1_data;
  assign op2 = (wb_valid && (wb_rd == rs2_addr)) ? wb_data : rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    x_rd      <= rd;
    x_rs1     <= rs1_addr;
    x_rs2     <= rs2_addr;
    x_op1     <= op1;
    x_op2     <= op2;
    x_imm     <= imm;
    x_use_imm <= use_imm;
    x_alu_op  <= alu_op;
  end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              x_valid,
  input  rv_pkg::reg_addr_t x_rd,
  input  rv_pkg::reg_addr_t x_rs1,
  input  rv_pkg::reg_addr_t x_rs2,
  input  rv_pkg::word_t     x_op1,
  input  rv_pkg::word_t     x_op2,
  input  rv_pkg::word_t     x_imm,
  input  logic              x_use_imm,
  input  rv_pkg::alu_op_t   x_alu_op,
  output logic              wb_valid,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data
);

  logic          fwd_a;
  logic          fwd_b;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t rs2_val;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_y;

  // ALU-to-ALU, previous result is still sitting in write-forward
  assign fwd_a = wb_valid && (wb_rd == x_rs1);
  assign fwd_b = wb_valid && !x_use_imm && (wb_rd == x_rs2);

  assign alu_a   = fwd_a ? wb_data : x_op1;
  assign rs2_val = fwd_b ? wb_data : x_op2;
  assign alu_b   = x_use_imm ? x_imm : rs2_val;

  alu i_alu (
    .op (x_alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  // Write-forward stage, also the register file write port
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= x_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= x_rd;
    wb_data <= alu_y;
  end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              instr_valid,
  input  rv_pkg::word_t     instr,
  output logic              wb_valid,
  output rv_pkg::reg_addr_t wb_rd,
  output rv_pkg::word_t     wb_data
);

  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  // Decode to execute
  logic              x_valid;
  rv_pkg::reg_addr_t x_rd;
  rv_pkg::reg_addr_t x_rs1;
  rv_pkg::reg_addr_t x_rs2;
  rv_pkg::word_t     x_op1;
  rv_pkg::word_t     x_op2;
  rv_pkg::word_t     x_imm;
  logic              x_use_imm;
  rv_pkg::alu_op_t   x_alu_op;

  decode_stage i_decode_stage (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .x_valid     (x_valid),
    .x_rd        (x_rd),
    .x_rs1       (x_rs1),
    .x_rs2       (x_rs2),
    .x_op1       (x_op1),
    .x_op2       (x_op2),
    .x_imm       (x_imm),
    .x_use_imm   (x_use_imm),
    .x_alu_op    (x_alu_op)
  );

  execute_stage i_execute_stage (
    .clk       (clk),
    .rst       (rst),
    .x_valid   (x_valid),
    .x_rd      (x_rd),
    .x_rs1     (x_rs1),
    .x_rs2     (x_rs2),
    .x_op1     (x_op1),
    .x_op2     (x_op2),
    .x_imm     (x_imm),
    .x_use_imm (x_use_imm),
    .x_alu_op  (x_alu_op),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  // Write-forward result lands in the file at the following edge
  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_valid),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data)
  );

endmodule

//--- tests/rv_core_props.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core_props (
  input logic              clk,
  input logic              rst,
  input logic              instr_valid,
  input rv_pkg::word_t     instr,
  input logic              wb_valid,
  input rv_pkg::reg_addr_t wb_rd
);

  logic kept_op;
  logic writes;

  assign kept_op = (instr[6:2] == `OPC_ARI_RTYPE) || (instr[6:2] == `OPC_ARI_ITYPE) ||
                   (instr[6:2] == `OPC_LUI);
  assign writes  = instr_valid && kept_op && (instr[11:7] != '0);

  // Pipeline comes out of reset empty
  assert property (@(posedge clk) rst |=> !wb_valid)
    else $error("wb_valid high right after reset");

  // Result register loads two edges after decode takes the instruction
  assert property (@(posedge clk) disable iff (rst) writes |-> ##3 wb_valid)
    else $error("writing instruction produced no wb_valid");

  assert property (@(posedge clk) disable iff (rst) wb_valid |-> $past(writes, 3))
    else $error("wb_valid without a writing instruction two edges before");

  assert property (@(posedge clk) disable iff (rst) wb_valid |-> (wb_rd != '0))
    else $error("write to x0 presented on wb_rd");

endmodule

bind rv_core rv_core_props i_rv_core_props (
  .clk         (clk),
  .rst         (rst),
  .instr_valid (instr_valid),
  .instr       (instr),
  .wb_valid    (wb_valid),
  .wb_rd       (wb_rd)
);

//--- tests/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  rv_pkg::word_t     instr;
  logic              wb_valid;
  rv_pkg::reg_addr_t wb_rd;
  rv_pkg::word_t     wb_data;

  rv_pkg::word_t     model [0:31]; // Architectural registers in program order
  logic [31:0]       lfsr;
  int                tick;
  int                value_errors;
  int                other_errors;
  string             test_name;
  int                exp_tick_q [$];
  rv_pkg::reg_addr_t exp_rd_q [$];
  rv_pkg::word_t     exp_data_q [$];

  rv_core i_rv_core (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'h80200003;
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  // RV32I result for register and immediate arithmetic
  function automatic rv_pkg::word_t expected_result(input rv_pkg::word_t ins,
                                                    input rv_pkg::word_t a,
                                                    input rv_pkg::word_t b);
    rv_pkg::word_t r;
    case (ins[14:12])
      3'b000:  r = (ins[30] && ins[5]) ? a - b : a + b; // sub exists only in register form
      3'b001:  r = a << b[4:0];
      3'b010:  r = {31'b0, $signed(a) < $signed(b)};
      3'b011:  r = {31'b0, a < b};
      3'b100:  r = a ^ b;
      3'b101: begin
        if (ins[30]) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic rv_pkg::word_t r_instr(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::reg_addr_t rd,
                                            input rv_pkg::reg_addr_t rs1,
                                            input rv_pkg::reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t i_instr(input logic [2:0] f3, input logic [11:0] imm,
                                            input rv_pkg::reg_addr_t rd,
                                            input rv_pkg::reg_addr_t rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  task automatic check_outputs();
    if (exp_tick_q.size() != 0 && exp_tick_q[0] == tick) begin
      assert (wb_valid) else begin
        other_errors++;
        $display("%s: no write was presented for x%0d", test_name, exp_rd_q[0]);
      end
      assert (wb_rd == exp_rd_q[0]) else begin
        value_errors++;
        $display("Fail %s: wb_rd expected %0d, actual %0d", test_name, exp_rd_q[0], wb_rd);
      end
      assert (wb_data == exp_data_q[0]) else begin
        value_errors++;
        $display("Fail %s: wb_data for x%0d expected %h, actual %h", test_name,
                 exp_rd_q[0], exp_data_q[0], wb_data);
      end
      void'(exp_tick_q.pop_front());
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
    end else begin
      assert (!wb_valid) else begin
        other_errors++;
        $display("%s: unexpected write to x%0d", test_name, wb_rd);
      end
    end
  endtask

  // Check this cycle, then drive the next instruction and update the model
  task automatic issue(input logic valid, input rv_pkg::word_t ins);
    rv_pkg::word_t     res;
    rv_pkg::reg_addr_t rd;
    logic              writes;
    @(negedge clk);
    tick++;
    check_outputs();
    instr_valid = valid;
    instr       = ins;
    rd          = ins[11:7];
    writes      = valid && (rd != '0);
    case (ins[6:0])
      7'b0110011: res = expected_result(ins, model[ins[19:15]], model[ins[24:20]]);
      7'b0010011: res = expected_result(ins, model[ins[19:15]], {{20{ins[31]}}, ins[31:20]});
      7'b0110111: res = {ins[31:12], 12'b0};
      default: begin
        res    = '0;
        writes = 1'b0; // Unsupported opcode is a bubble
      end
    endcase
    if (writes) begin
      model[rd] = res;
      exp_tick_q.push_back(tick + 3); // Visible two edges after the sampling edge
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
    end
  endtask

  task automatic issue_random();
    logic [31:0]   cls;
    logic [31:0]   f3;
    logic [31:0]   alt;
    logic [31:0]   rd;
    logic [31:0]   rs1;
    logic [31:0]   rs2;
    logic [31:0]   imm;
    logic [31:0]   gap;
    rv_pkg::word_t ins;
    cls = take_bits(2);
    f3  = take_bits(3);
    alt = take_bits(1);
    rd  = take_bits(3); // x0 to x7 keeps hazards frequent
    rs1 = take_bits(3);
    rs2 = take_bits(3);
    imm = take_bits(20);
    gap = take_bits(3);
    if (f3[2:0] != 3'b000 && f3[2:0] != 3'b101) begin
      alt = '0;
    end
    case (cls[1:0])
      2'd0: ins = r_instr(f3[2:0], alt[0], rd[4:0], rs1[4:0], rs2[4:0]);
      2'd1: begin
        if (f3[1:0] == 2'b01) begin
          ins = i_instr(f3[2:0], {1'b0, alt[0], 5'b0, imm[4:0]}, rd[4:0], rs1[4:0]);
        end else begin
          ins = i_instr(f3[2:0], imm[11:0], rd[4:0], rs1[4:0]);
        end
      end
      2'd2:    ins = {imm[19:0], rd[4:0], 7'b0110111};
      default: ins = {imm[19:0], rd[4:0], 7'b0000011}; // Load opcode is not kept
    endcase
    issue(gap[2:0] != 3'b000, ins);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_tick_q.size() != 0 && n < 10) begin
      issue(1'b0, '0);
      n++;
    end
    if (exp_tick_q.size() != 0) begin
      other_errors++;
      $display("%s: timeout waiting for %0d writes", test_name, exp_tick_q.size());
      exp_tick_q.delete();
      exp_rd_q.delete();
      exp_data_q.delete();
    end
  endtask

  initial begin
    rst          = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    lfsr         = 32'h58b6cb92;
    tick         = 0;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) issue(1'b0, '0);

    test_name = "forwarding";
    issue(1'b1, i_instr(3'b000, 12'd100, 5'd1, 5'd0));
    issue(1'b1, i_instr(3'b000, 12'hffd, 5'd2, 5'd0));
    issue(1'b1, r_instr(3'b000, 1'b1, 5'd3, 5'd1, 5'd2)); // Distance 2 and 1
    issue(1'b1, r_instr(3'b100, 1'b0, 5'd4, 5'd3, 5'd1)); // Distance 1 and 3
    issue(1'b1, i_instr(3'b000, 12'd1, 5'd4, 5'd4));
    issue(1'b0, '0);
    issue(1'b1, i_instr(3'b000, 12'd1, 5'd4, 5'd4)); // Across a bubble
    issue(1'b0, '0);
    issue(1'b0, '0);
    issue(1'b1, r_instr(3'b101, 1'b1, 5'd5, 5'd2, 5'd4));
    issue(1'b1, {20'h8765f, 5'd1, 7'b0110111});
    issue(1'b1, i_instr(3'b110, 12'h00f, 5'd1, 5'd1));
    drain();

    test_name = "x0";
    issue(1'b1, i_instr(3'b000, 12'd55, 5'd0, 5'd1)); // Dropped write to x0
    issue(1'b1, r_instr(3'b000, 1'b0, 5'd6, 5'd0, 5'd0));
    issue(1'b1, i_instr(3'b110, 12'h0f0, 5'd7, 5'd0));
    drain();

    test_name = "random";
    repeat (400) issue_random();
    drain();

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rv_core_tb \
  -Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
